// File: Bender.yml
package:
  name: rf_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rf_pkg.sv
      - rf_issue_if.sv
      - toggle_memory_set.sv
      - lutram_1w_mr.sv
      - register_file.sv
      - decode_stage.sv
      - issue_stage.sv
      - rf_subsystem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rf_subsystem.sv

// File: compile.f
+incdir+.
rf_pkg.sv
rf_issue_if.sv
toggle_memory_set.sv
lutram_1w_mr.sv
register_file.sv
decode_stage.sv
issue_stage.sv
rf_subsystem_top.sv
tb_rf_subsystem.sv

// File: decode_stage.sv
// Decode holding stage

`timescale 1ns/1ps

module decode_stage
    import rf_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  decoded_op_t in_op,
    input  logic        issue_free,
    output decoded_op_t op,
    output logic        decode_advance
);

    logic        valid_r;
    decoded_op_t op_r;
    logic        accept;

    // Move on whenever issue can take the operation
    assign decode_advance = valid_r & issue_free;
    assign in_ready = ~valid_r | decode_advance;
    assign accept = in_valid & in_ready;
    assign op = op_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (accept) begin
            valid_r <= 1'b1;
        end else if (decode_advance) begin
            valid_r <= 1'b0;
        end
    end

    // Register 0 destination never tracked
    always_ff @(posedge clk) begin
        if (accept) begin
            op_r <= in_op;
            op_r.uses_rd <= in_op.uses_rd & (|in_op.rd_addr);
        end
    end

endmodule

// File: issue_stage.sv
// Issue holding stage

`timescale 1ns/1ps

`include "rf_defines.svh"

module issue_stage
    import rf_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  decoded_op_t   op,
    input  logic          decode_advance,
    output logic          issue_free,
    rf_issue_if.issue     rf_issue,
    output logic          out_valid,
    input  logic          out_ready,
    output op_tag_t       out_tag,
    output phys_addr_t    out_rd,
    output wb_group_t     out_group,
    output rf_data_t      out_rs1_data,
    output rf_data_t      out_rs2_data
);

    logic        valid_r;
    decoded_op_t op_r;
    logic        operands_ready;
    logic        issue_accept;

    // Wait until no source has a pending writer
    always_comb begin
        operands_ready = 1'b1;
        for (int i = 0; i < `RF_READ_PORTS; i++) begin
            rf_issue.phys_rs_addr[i] = op_r.rs_addr[i];
            operands_ready = operands_ready & ~rf_issue.inuse[i];
        end
    end

    assign out_valid = valid_r & operands_ready;
    assign issue_accept = out_valid & out_ready;
    assign issue_free = ~valid_r | issue_accept;

    // Group 0 writers release their destination here
    assign rf_issue.phys_rd_addr = op_r.rd_addr;
    assign rf_issue.single_cycle_issue = issue_accept & op_r.uses_rd & (op_r.rd_group == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (decode_advance) begin
            valid_r <= 1'b1;
        end else if (issue_accept) begin
            valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            op_r <= op;
        end
    end

    // Output payload
    assign out_tag = op_r.tag;
    assign out_rd = op_r.rd_addr;
    assign out_group = op_r.rd_group;
    assign out_rs1_data = rf_issue.data[0];
    assign out_rs2_data = rf_issue.data[1];

endmodule

// File: lutram_1w_mr.sv
// One-write multi-read register bank

`timescale 1ns/1ps

`include "rf_defines.svh"

module lutram_1w_mr
    import rf_pkg::*;
#(
    parameter int NUM_READ_PORTS = 2
) (
    input  logic       clk,
    input  phys_addr_t waddr,
    input  phys_addr_t raddr [NUM_READ_PORTS],
    input  logic       ram_write,
    input  rf_data_t   new_ram_data,
    output rf_data_t   ram_data_out [NUM_READ_PORTS]
);

    // Distributed RAM storage
    rf_data_t ram [`RF_DEPTH];

    // Single synchronous write
    always_ff @(posedge clk) begin
        if (ram_write) begin
            ram[waddr] <= new_ram_data;
        end
    end

    // Asynchronous reads, one per port
    for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : g_read
        assign ram_data_out[i] = ram[raddr[i]];
    end

endmodule

// File: register_file.sv
// Physical register file with in-use tracking

`timescale 1ns/1ps

`include "rf_defines.svh"

module register_file
    import rf_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  decoded_op_t        op,
    input  logic               decode_advance,
    input  logic               wb_valid [`RF_WB_GROUPS],
    input  phys_addr_t         wb_addr [`RF_WB_GROUPS],
    input  rf_data_t           wb_data [`RF_WB_GROUPS],
    rf_issue_if.register_file  rf_issue
);

    localparam int RP = `RF_READ_PORTS;
    localparam int TOGGLE_PORTS = `RF_WB_GROUPS + 1;

    logic       toggle [TOGGLE_PORTS];
    phys_addr_t toggle_addr [TOGGLE_PORTS];
    phys_addr_t inuse_addr [2*RP];
    logic       inuse [2*RP];
    phys_addr_t decode_rs_addr [RP];
    logic       release_r;
    phys_addr_t release_addr_r;

    rf_data_t   bank_data [`RF_WB_GROUPS][RP];
    rf_data_t   rs_data_r [RP];
    rf_data_t   bypass_r [`RF_WB_GROUPS][RP];
    logic       use_bypass_r [RP];
    wb_group_t  bypass_group_r [RP];

    //////////////////////////////////////////////////////////////////////
    // In-use tracking

    // Group 0 release delayed to the edge its result lands
    // so a waiting reader still captures it in bypass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            release_r <= 1'b0;
        end else begin
            release_r <= rf_issue.single_cycle_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_issue.single_cycle_issue) begin
            release_addr_r <= rf_issue.phys_rd_addr;
        end
    end

    always_comb begin
        // Read ports: decode sources then issue sources
        for (int i = 0; i < RP; i++) begin
            decode_rs_addr[i] = op.rs_addr[i];
            inuse_addr[i] = op.rs_addr[i];
            inuse_addr[i+RP] = rf_issue.phys_rs_addr[i];
            rf_issue.inuse[i] = inuse[i+RP];
        end
        // Port 0 marks, register 0 never tracked
        toggle[0] = decode_advance & op.uses_rd & (|op.rd_addr);
        toggle_addr[0] = op.rd_addr;
        // Port 1 single-cycle release
        toggle[1] = release_r;
        toggle_addr[1] = release_addr_r;
        // Remaining ports release on multi-cycle writeback
        for (int g = 1; g < `RF_WB_GROUPS; g++) begin
            toggle[g+1] = wb_valid[g] & (|wb_addr[g]);
            toggle_addr[g+1] = wb_addr[g];
        end
    end

    toggle_memory_set #(
        .NUM_WRITE_PORTS (TOGGLE_PORTS),
        .NUM_READ_PORTS  (2*RP)
    ) i_inuse_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .toggle      (toggle),
        .toggle_addr (toggle_addr),
        .read_addr   (inuse_addr),
        .in_use      (inuse)
    );

    //////////////////////////////////////////////////////////////////////
    // Register banks, one per writeback group

    for (genvar g = 0; g < `RF_WB_GROUPS; g++) begin : g_bank
        lutram_1w_mr #(
            .NUM_READ_PORTS (RP)
        ) i_bank (
            .clk          (clk),
            .waddr        (wb_addr[g]),
            .raddr        (decode_rs_addr),
            .ram_write    (wb_valid[g]),
            .new_ram_data (wb_data[g]),
            .ram_data_out (bank_data[g])
        );
    end

    // Decode read, registered with its operand source
    always_ff @(posedge clk) begin
        for (int i = 0; i < RP; i++) begin
            if (decode_advance) begin
                rs_data_r[i] <= (op.rs_addr[i] == '0) ? '0 : bank_data[op.rs_group[i]][i];
                use_bypass_r[i] <= inuse[i];
                bypass_group_r[i] <= op.rs_group[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bypass registers and operand mux

    // Last capture before release holds the awaited result
    always_ff @(posedge clk) begin
        for (int g = 0; g < `RF_WB_GROUPS; g++) begin
            for (int j = 0; j < RP; j++) begin
                if (decode_advance | inuse[j+RP]) begin
                    bypass_r[g][j] <= wb_data[g];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RP; i++) begin
            rf_issue.data[i] = use_bypass_r[i] ? bypass_r[bypass_group_r[i]][i] : rs_data_r[i];
        end
    end

endmodule

// File: rf_defines.svh
// Register file subsystem parameters

`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// Physical register count
`define RF_DEPTH 64

// Register word width
`define RF_DATA_W 32

// Writeback groups
// group 0 single-cycle, group 1 multi-cycle
`define RF_WB_GROUPS 2

// Source operands per operation
`define RF_READ_PORTS 2

`endif

// File: rf_issue_if.sv
// Register file to issue link

`timescale 1ns/1ps

`include "rf_defines.svh"

interface rf_issue_if import rf_pkg::*; ();

    // Issue side: held operation addresses
    phys_addr_t phys_rs_addr [`RF_READ_PORTS];
    phys_addr_t phys_rd_addr;
    // Accepted issue of a group 0 writer
    logic       single_cycle_issue;

    // Register file side: live state and operands
    logic       inuse [`RF_READ_PORTS];
    rf_data_t   data [`RF_READ_PORTS];

    modport register_file (
        input  phys_rs_addr, phys_rd_addr, single_cycle_issue,
        output inuse, data
    );

    modport issue (
        output phys_rs_addr, phys_rd_addr, single_cycle_issue,
        input  inuse, data
    );

endinterface

// File: rf_pkg.sv
// Register file subsystem types

`include "rf_defines.svh"

package rf_pkg;

    // Physical register index
    typedef logic [$clog2(`RF_DEPTH)-1:0] phys_addr_t;

    // One register word
    typedef logic [`RF_DATA_W-1:0] rf_data_t;

    // Writeback group index
    typedef logic [$clog2(`RF_WB_GROUPS)-1:0] wb_group_t;

    // Opaque tag, passed through to the output
    typedef logic [7:0] op_tag_t;

    // Renamed operation as seen by decode
    typedef struct packed {
        phys_addr_t [`RF_READ_PORTS-1:0] rs_addr;
        wb_group_t [`RF_READ_PORTS-1:0]  rs_group;
        phys_addr_t                      rd_addr;
        logic                            uses_rd;
        wb_group_t                       rd_group;
        op_tag_t                         tag;
    } decoded_op_t;

endpackage

// File: rf_subsystem_top.sv
// Operand-read subsystem top

`timescale 1ns/1ps

`include "rf_defines.svh"

module rf_subsystem_top
    import rf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Input handshake and operation fields
    input  logic       in_valid,
    output logic       in_ready,
    input  phys_addr_t rs1_addr,
    input  phys_addr_t rs2_addr,
    input  wb_group_t  rs1_group,
    input  wb_group_t  rs2_group,
    input  phys_addr_t rd_addr,
    input  logic       uses_rd,
    input  wb_group_t  rd_group,
    input  op_tag_t    tag,
    // Output handshake
    output logic       out_valid,
    input  logic       out_ready,
    output op_tag_t    out_tag,
    output phys_addr_t out_rd,
    output wb_group_t  out_group,
    output rf_data_t   out_rs1_data,
    output rf_data_t   out_rs2_data,
    // Writeback per group
    input  logic       wb_valid [`RF_WB_GROUPS],
    input  phys_addr_t wb_addr [`RF_WB_GROUPS],
    input  rf_data_t   wb_data [`RF_WB_GROUPS]
);

    decoded_op_t in_op;
    decoded_op_t op;
    logic        decode_advance;
    logic        issue_free;

    rf_issue_if i_rf_issue ();

    // Pack input fields
    assign in_op.rs_addr[0] = rs1_addr;
    assign in_op.rs_addr[1] = rs2_addr;
    assign in_op.rs_group[0] = rs1_group;
    assign in_op.rs_group[1] = rs2_group;
    assign in_op.rd_addr = rd_addr;
    assign in_op.uses_rd = uses_rd;
    assign in_op.rd_group = rd_group;
    assign in_op.tag = tag;

    decode_stage i_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .issue_free     (issue_free),
        .op             (op),
        .decode_advance (decode_advance)
    );

    register_file i_register_file (
        .clk            (clk),
        .rst_n          (rst_n),
        .op             (op),
        .decode_advance (decode_advance),
        .wb_valid       (wb_valid),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .rf_issue       (i_rf_issue.register_file)
    );

    issue_stage i_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .op             (op),
        .decode_advance (decode_advance),
        .issue_free     (issue_free),
        .rf_issue       (i_rf_issue.issue),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_tag        (out_tag),
        .out_rd         (out_rd),
        .out_group      (out_group),
        .out_rs1_data   (out_rs1_data),
        .out_rs2_data   (out_rs2_data)
    );

endmodule

// File: tb_rf_subsystem.sv
// Operand-read subsystem testbench

`timescale 1ns/1ps

`include "rf_defines.svh"

module tb_rf_subsystem
    import rf_pkg::*;
();

    localparam int NUM_OPS = 300;
    localparam int CLK_PERIOD = 10;
    localparam logic [31:0] SEED = 32'hc1b088ed;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    phys_addr_t rs1_addr;
    phys_addr_t rs2_addr;
    wb_group_t  rs1_group;
    wb_group_t  rs2_group;
    phys_addr_t rd_addr;
    logic       uses_rd;
    wb_group_t  rd_group;
    op_tag_t    tag;
    logic       out_valid;
    logic       out_ready;
    op_tag_t    out_tag;
    phys_addr_t out_rd;
    wb_group_t  out_group;
    rf_data_t   out_rs1_data;
    rf_data_t   out_rs2_data;
    logic       wb_valid [`RF_WB_GROUPS];
    phys_addr_t wb_addr [`RF_WB_GROUPS];
    rf_data_t   wb_data [`RF_WB_GROUPS];
    logic       out_fire;

    // Reference model state
    logic [31:0] lfsr;
    rf_data_t    model_val [`RF_DEPTH];
    wb_group_t   model_grp [`RF_DEPTH];
    int          last_writer [`RF_DEPTH];
    phys_addr_t  last_dest;
    bit          wb_done [NUM_OPS];
    phys_addr_t  op_rs1 [NUM_OPS];
    phys_addr_t  op_rs2 [NUM_OPS];
    phys_addr_t  op_rd [NUM_OPS];
    wb_group_t   op_grp [NUM_OPS];
    bit          op_wr [NUM_OPS];
    int          op_w1 [NUM_OPS];
    int          op_w2 [NUM_OPS];
    int          exp_q [$];
    int          g1_id [$];
    int          g1_due [$];
    int          wb_id [`RF_WB_GROUPS];
    int          errors;
    int          out_count;
    int          fire_count;
    int          res_cnt;
    int          cyc;

    // Expected values at the next edge
    bit          exp_valid;
    bit          exp_pend;
    op_tag_t     exp_tag;
    rf_data_t    exp_rs1;
    rf_data_t    exp_rs2;
    phys_addr_t  exp_rd;
    wb_group_t   exp_grp;
    bit          stall_prev;
    op_tag_t     prev_tag;
    logic [63:0] prev_data;

    rf_subsystem_top i_dut (.*);

    assign out_fire = out_valid && out_ready;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every output handshake, also any after the last expected one
    always @(posedge clk) begin
        if (rst_n && out_fire) begin
            fire_count <= fire_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic rf_data_t fill_value(input int a);
        return (rf_data_t'(a) * 32'h0101_0101) ^ 32'h5a00_0000;
    endfunction

    function automatic rf_data_t model_read(input phys_addr_t a);
        return (a == '0) ? '0 : model_val[a];
    endfunction

    function automatic bit writer_pending(input int w);
        if (w < 0) begin
            return 1'b0;
        end
        return !wb_done[w];
    endfunction

    // Biased toward the latest destination for back-to-back RAW
    function automatic phys_addr_t pick_source();
        int sel;
        sel = take_bits(3);
        if (sel < 3) begin
            return last_dest;
        end else if (sel == 3) begin
            return '0;
        end
        return phys_addr_t'(take_bits(6));
    endfunction

    task automatic record_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        errors++;
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
    endtask

    task automatic record_failure(input string what);
        errors++;
        $display("ERROR %s", what);
    endtask

    // Renaming never reuses a pending or own-source destination
    task automatic drive_op(input int id);
        phys_addr_t rd;
        bit         want_rd;
        bit         writer;
        op_rs1[id] = pick_source();
        op_rs2[id] = pick_source();
        rd = phys_addr_t'(take_bits(6));
        want_rd = take_bits(3) != 0;
        op_grp[id] = wb_group_t'(take_bits(1));
        writer = want_rd && rd != '0 && rd != op_rs1[id] && rd != op_rs2[id]
                 && !writer_pending(last_writer[rd]);
        op_rd[id] = rd;
        op_wr[id] = writer;
        op_w1[id] = (op_rs1[id] == '0) ? -1 : last_writer[op_rs1[id]];
        op_w2[id] = (op_rs2[id] == '0) ? -1 : last_writer[op_rs2[id]];
        in_valid = 1'b1;
        rs1_addr = op_rs1[id];
        rs2_addr = op_rs2[id];
        rs1_group = model_grp[op_rs1[id]];
        rs2_group = model_grp[op_rs2[id]];
        rd_addr = rd;
        rd_group = op_grp[id];
        // rd 0 with uses_rd set must be ignored by decode
        uses_rd = writer || (want_rd && rd == '0);
        tag = op_tag_t'(id);
        if (writer) begin
            last_writer[rd] = id;
            model_grp[rd] = op_grp[id];
            last_dest = rd;
        end
    endtask

    // Result word: counter above the tag
    task automatic start_writeback(input int g, input int id);
        wb_valid[g] = 1'b1;
        wb_addr[g] = op_rd[id];
        wb_data[g] = (rf_data_t'(res_cnt) << 8) + rf_data_t'(op_tag_t'(id));
        wb_id[g] = id;
        res_cnt++;
    endtask

    // Write landed on the last edge
    task automatic complete_writebacks();
        for (int g = 0; g < `RF_WB_GROUPS; g++) begin
            if (wb_valid[g]) begin
                model_val[wb_addr[g]] = wb_data[g];
                wb_done[wb_id[g]] = 1'b1;
                wb_valid[g] = 1'b0;
            end
        end
    endtask

    task automatic update_expected();
        int id;
        exp_valid = exp_q.size() > 0;
        if (exp_valid) begin
            id = exp_q[0];
            exp_tag = op_tag_t'(id);
            exp_rs1 = model_read(op_rs1[id]);
            exp_rs2 = model_read(op_rs2[id]);
            exp_rd = op_rd[id];
            exp_grp = op_grp[id];
            exp_pend = writer_pending(op_w1[id]) || writer_pending(op_w2[id]);
        end
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d of %0d operations out, %0d errors", out_count, NUM_OPS, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_reset: assert property (@(posedge clk) (rst_n && !$past(rst_n)) |->
                              (!out_valid && in_ready))
        else record_mismatch("reset_state", 64'b01, {$sampled(out_valid), $sampled(in_ready)});

    a_known: assert property (@(posedge clk) disable iff (!rst_n) out_fire |-> exp_valid)
        else record_failure("output handshake with no operation outstanding");

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
                              (out_fire && exp_valid) |-> out_tag == exp_tag)
        else record_mismatch("out_tag", $sampled(exp_tag), $sampled(out_tag));

    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
                           (out_fire && exp_valid) |-> out_rd == exp_rd)
        else record_mismatch("out_rd", $sampled(exp_rd), $sampled(out_rd));

    a_group: assert property (@(posedge clk) disable iff (!rst_n)
                              (out_fire && exp_valid) |-> out_group == exp_grp)
        else record_mismatch("out_group", $sampled(exp_grp), $sampled(out_group));

    a_raw: assert property (@(posedge clk) disable iff (!rst_n)
                            (out_fire && exp_valid) |-> !exp_pend)
        else record_failure("operation issued before its source writeback");

    a_rs1: assert property (@(posedge clk) disable iff (!rst_n)
                            (out_fire && exp_valid) |-> out_rs1_data == exp_rs1)
        else record_mismatch("rs1_data", $sampled(exp_rs1), $sampled(out_rs1_data));

    a_rs2: assert property (@(posedge clk) disable iff (!rst_n)
                            (out_fire && exp_valid) |-> out_rs2_data == exp_rs2)
        else record_mismatch("rs2_data", $sampled(exp_rs2), $sampled(out_rs2_data));

    // Stalled output holds
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n) stall_prev |-> out_valid)
        else record_failure("out_valid dropped before its handshake");

    a_hold_tag: assert property (@(posedge clk) disable iff (!rst_n)
                                 stall_prev |-> out_tag == prev_tag)
        else record_mismatch("hold_tag", $sampled(prev_tag), $sampled(out_tag));

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
                                  stall_prev |-> {out_rs1_data, out_rs2_data} == prev_data)
        else record_mismatch("hold_data", $sampled(prev_data),
                             {$sampled(out_rs1_data), $sampled(out_rs2_data)});

    //////////////////////////////////////////////////////////////////////
    // Stimulus and execution units

    initial begin
        int          id;
        int          gen_id;
        int          lat;
        bit          s_in_fire;
        bit          s_out_fire;
        bit          s_stall;
        op_tag_t     s_tag;
        logic [63:0] s_data;
        lfsr = SEED;
        rst_n = 1'b0;
        in_valid = 1'b0;
        rs1_addr = '0;
        rs2_addr = '0;
        rs1_group = '0;
        rs2_group = '0;
        rd_addr = '0;
        uses_rd = 1'b0;
        rd_group = '0;
        tag = '0;
        out_ready = 1'b0;
        for (int g = 0; g < `RF_WB_GROUPS; g++) begin
            wb_valid[g] = 1'b0;
            wb_addr[g] = '0;
            wb_data[g] = '0;
            wb_id[g] = 0;
        end
        for (int a = 0; a < `RF_DEPTH; a++) begin
            model_val[a] = '0;
            model_grp[a] = '0;
            last_writer[a] = -1;
        end
        last_dest = phys_addr_t'(1);
        errors = 0;
        out_count = 0;
        fire_count = 0;
        res_cnt = 0;
        cyc = 0;
        gen_id = 0;
        exp_valid = 1'b0;
        exp_pend = 1'b0;
        stall_prev = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Prefill through the group 0 port, no in-use change
        for (int a = 1; a < `RF_DEPTH; a++) begin
            wb_valid[0] = 1'b1;
            wb_addr[0] = phys_addr_t'(a);
            wb_data[0] = fill_value(a);
            model_val[a] = fill_value(a);
            @(posedge clk);
            #1;
        end
        wb_valid[0] = 1'b0;
        while (out_count < NUM_OPS || g1_id.size() > 0 || wb_valid[0] || wb_valid[1]) begin
            @(negedge clk);
            s_in_fire = in_valid && in_ready;
            s_out_fire = out_valid && out_ready;
            s_stall = out_valid && !out_ready;
            s_tag = out_tag;
            s_data = {out_rs1_data, out_rs2_data};
            @(posedge clk);
            #1;
            cyc++;
            complete_writebacks();
            if (s_out_fire && exp_q.size() > 0) begin
                id = exp_q.pop_front();
                out_count++;
                // Group 0 result due exactly one cycle after issue
                if (op_wr[id] && op_grp[id] == '0) begin
                    start_writeback(0, id);
                end else if (op_wr[id]) begin
                    lat = (take_bits(3) % 6) + 1;
                    g1_id.push_back(id);
                    g1_due.push_back(cyc + lat - 1);
                end
            end
            if (g1_id.size() > 0 && g1_due[0] <= cyc) begin
                start_writeback(1, g1_id.pop_front());
                void'(g1_due.pop_front());
            end
            if (s_in_fire) begin
                exp_q.push_back(gen_id);
                gen_id++;
                in_valid = 1'b0;
            end
            if (!in_valid && gen_id < NUM_OPS && take_bits(2) != 0) begin
                drive_op(gen_id);
            end
            out_ready = take_bits(2) != 0;
            stall_prev = s_stall;
            prev_tag = s_tag;
            prev_data = s_data;
            update_expected();
        end
        // Drain so late extra handshakes are counted too
        repeat (4) @(posedge clk);
        #1;
        a_complete: assert (fire_count == NUM_OPS && exp_q.size() == 0)
            else record_mismatch("completeness", 64'(NUM_OPS), 64'(fire_count));
        report_and_finish();
    end

    // Watchdog sized from the operation count plus prefill
    initial begin
        #((NUM_OPS * 20 + `RF_DEPTH) * CLK_PERIOD);
        record_failure("timeout, operations did not all complete");
        report_and_finish();
    end

endmodule

// File: toggle_memory_set.sv
// Multi-port in-use bit memory

`timescale 1ns/1ps

`include "rf_defines.svh"

module toggle_memory_set
    import rf_pkg::*;
#(
    parameter int NUM_WRITE_PORTS = 3,
    parameter int NUM_READ_PORTS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       toggle [NUM_WRITE_PORTS],
    input  phys_addr_t toggle_addr [NUM_WRITE_PORTS],
    input  phys_addr_t read_addr [NUM_READ_PORTS],
    output logic       in_use [NUM_READ_PORTS]
);

    // One bit bank per write port
    logic [`RF_DEPTH-1:0] bank [NUM_WRITE_PORTS];

    //////////////////////////////////////////////////////////////////////
    // Toggle banks

    // Each port flips only its own bank, no write conflicts
    for (genvar w = 0; w < NUM_WRITE_PORTS; w++) begin : g_bank
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                bank[w] <= '0;
            end else if (toggle[w]) begin
                bank[w][toggle_addr[w]] <= ~bank[w][toggle_addr[w]];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Parity read

    // Set and clear on different ports cancel out
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
                in_use[r] = in_use[r] ^ bank[w][read_addr[r]];
            end
        end
    end

endmodule
